/* flist.f */
+incdir+design
design/vic_pkg.sv
design/vic_phase_ctrl.sv
design/vic_raster_counter.sv
design/vic_reg_file.sv
design/vic_irq_unit.sv
design/vic_bus_sequencer.sv
design/vicii.sv
testbench/vicii_checker.sv
testbench/tb_vicii.sv

/* run_sim.sh */
#!/bin/sh
# build and run the vicii testbench with verilator, result taken from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_vicii -f flist.f -o vicii_sim \
  && ./obj_dir/vicii_sim +verilator+error+limit+100 > sim.log 2>&1 \
  || echo "build or simulation stopped with an error"
cat sim.log 2>/dev/null
grep -q "Simulation completed successfully" sim.log 2>/dev/null \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

/* testbench/tb_vicii.sv */
`include "vic_defines.svh"

module tb_vicii import vic_pkg::*; ();

  localparam int line_clocks = `VIC_CYCLES_PER_LINE * 16; // 16 dot clocks per phi cycle
  localparam int frame_clocks = line_clocks * `VIC_LINES_PER_FRAME;

  logic clk_dot4x, rst_n, ce, rw, lp;
  reg_addr_t adi;
  vic_data_t dbi, dbo;
  logic clk_phi, cpu_reset, ras, cas, irq, ba, aec;
  bus_addr_t ado;
  logic vic_write_ab, vic_write_db, ls245_data_dir, ls245_addr_dir;
  logic [31:0] lfsr_q;
  int err_count, check_count;

  vicii u_vicii (.*);

  bind vicii vicii_checker u_checker (.*);

  initial begin
    clk_dot4x = 1'b0;
    forever #20 clk_dot4x = ~clk_dot4x;
  end

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q); // one step per bit
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  task automatic check_true(input logic ok, input string what);
    check_count++;
    assert (ok) else begin
      $display("Fail at %0t: %s", $time, what);
      err_count++;
    end
  endtask

  task automatic check_value(input vic_data_t got, input vic_data_t exp, input string what);
    check_count++;
    assert (got === exp) else begin
      $display("Fail at %0t: %s read %h, expected %h", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic report_test(input string name, input int first_err);
    $display("test %s done with %0d errors", name, err_count - first_err);
  endtask

  task automatic step_clock();
    @(posedge clk_dot4x);
    #5; // inputs change and outputs settle here
  endtask

  task automatic abort_on_timeout(input string why);
    $display("timeout, %s", why);
    $display("Simulation failed");
    $finish;
  endtask

  // returns in sub-phase 8 on the first clock of the cpu half
  task automatic wait_phi_rise();
    logic prev;
    int n;
    prev = clk_phi;
    n = 0;
    step_clock();
    while (!(clk_phi && !prev)) begin
      prev = clk_phi;
      step_clock();
      n++;
      if (n > 40) begin
        abort_on_timeout("clk_phi never rose");
      end
    end
  endtask

  // one cpu bus cycle with data sampled at sub-phase 15
  task automatic cpu_access(input logic is_write, input reg_addr_t addr, input vic_data_t data,
                            output vic_data_t rd);
    wait_phi_rise();
    ce = 1'b0;
    rw = ~is_write;
    adi = addr;
    dbi = data;
    repeat (7) step_clock();
    rd = dbo;
    check_true(vic_write_db == !is_write && ls245_data_dir == !is_write,
               "data bus drive in the cpu half");
    step_clock(); // back in the vic half
    ce = 1'b1;
    rw = 1'b1;
  endtask

  task automatic cpu_write(input reg_addr_t addr, input vic_data_t data);
    vic_data_t unused_rd;
    cpu_access(1'b1, addr, data, unused_rd);
  endtask

  task automatic cpu_read(input reg_addr_t addr, output vic_data_t rd);
    cpu_access(1'b0, addr, 8'h00, rd);
  endtask

  task automatic read_line(output int line);
    vic_data_t hi, lo;
    cpu_read(6'h11, hi); // bit 7 is line bit 8
    cpu_read(6'h12, lo);
    line = int'({hi[7], lo});
  endtask

  // clocks until irq or ba reaches level or -1 on timeout
  task automatic clocks_until(input logic use_ba, input logic level, input int max_clocks,
                              output int clocks);
    logic sig;
    clocks = -1;
    for (int n = 1; n <= max_clocks && clocks < 0; n++) begin
      step_clock();
      if (vic_write_ab) begin
        check_true(ado[11:6] == 6'h3f, "ado upper bits during refresh");
      end
      sig = use_ba ? ba : irq;
      if (sig == level) begin
        clocks = n;
      end
    end
  endtask

  task automatic reset_and_phase();
    int first, n, s;
    logic ok;
    first = err_count;
    ok = 1'b1;
    n = 0;
    repeat (10) @(posedge clk_dot4x);
    #5;
    rst_n = 1'b1;
    while (cpu_reset && n < 200) begin
      step_clock();
      n++;
      ok = ok && irq && ba;
    end
    check_true(n == `VIC_RESET_HOLD_CYCLES * 16, "cpu_reset length after rst_n");
    check_true(ok, "irq and ba high through the reset hold");
    wait_phi_rise();
    for (int i = 0; i < 16; i++) begin
      s = (i + 8) % 16; // counted from the phi rise
      check_true(clk_phi == (s >= 8) && aec == (s >= 8) &&
                 ras == !((s >= 2 && s <= 7) || s >= 10) &&
                 cas == !((s >= 4 && s <= 7) || s >= 12),
                 $sformatf("strobes at sub-phase %0d", s));
      step_clock();
    end
    report_test("reset and phase", first);
  endtask

  task automatic register_access();
    int first;
    logic [31:0] v;
    vic_data_t rd;
    first = err_count;
    random_bits(8, v);
    cpu_write(6'h20, v[7:0]);
    cpu_read(6'h20, rd);
    check_value(rd, {4'hf, v[3:0]}, "border");
    random_bits(8, v);
    cpu_write(6'h1a, v[7:0]);
    cpu_read(6'h1a, rd);
    check_value(rd, {4'hf, v[3:0]}, "irq enable");
    cpu_write(6'h1a, 8'h00);
    cpu_read(6'h00, rd);
    check_value(rd, 8'hff, "unused address 00");
    cpu_read(6'h3f, rd);
    check_value(rd, 8'hff, "unused address 3f");
    report_test("register access", first);
  endtask

  task automatic raster_read();
    int first, line;
    vic_data_t rd;
    first = err_count;
    read_line(line);
    repeat (62) wait_phi_rise(); // read below lands 63 cycles on
    cpu_read(6'h12, rd);
    check_value(rd, 8'((line + 1) % `VIC_LINES_PER_FRAME), "line one line later");
    report_test("raster read", first);
  endtask

  task automatic set_compare(input int cmp);
    cpu_write(6'h12, 8'(cmp));
    cpu_write(6'h11, {cmp[8], 7'b0000000}); // den off
  endtask

  task automatic raster_interrupt();
    int first, line, n;
    vic_data_t rd;
    first = err_count;
    read_line(line);
    set_compare((line + 2) % `VIC_LINES_PER_FRAME);
    cpu_write(6'h1a, 8'h01);
    clocks_until(1'b0, 1'b0, 3 * line_clocks, n);
    check_true(n > 0, "irq low within 3 lines of the compare");
    cpu_read(6'h19, rd);
    check_value(rd, 8'hf1, "status after raster match");
    cpu_write(6'h19, 8'h01);
    repeat (2) step_clock(); // status register then irq register
    check_true(irq, "irq high after clearing raster status");
    cpu_write(6'h1a, 8'h00);
    read_line(line);
    set_compare((line + 2) % `VIC_LINES_PER_FRAME);
    clocks_until(1'b0, 1'b0, 3 * line_clocks, n);
    check_true(n < 0, "irq stays high with raster enable clear");
    cpu_read(6'h19, rd);
    check_value(rd, 8'h71, "masked raster status");
    cpu_write(6'h19, 8'h01);
    report_test("raster interrupt", first);
  endtask

  task automatic light_pen();
    int first, n;
    vic_data_t rd;
    first = err_count;
    lp = 1'b0;
    repeat (4) step_clock(); // two sync flops plus edge
    lp = 1'b1;
    cpu_read(6'h19, rd);
    check_value(rd, 8'h78, "light pen status while masked");
    check_true(irq, "irq high with light pen masked");
    cpu_write(6'h19, 8'h08);
    cpu_write(6'h1a, 8'h08);
    repeat (2) step_clock();
    check_true(irq, "irq high before the second pen edge");
    lp = 1'b0;
    clocks_until(1'b0, 1'b0, 8, n);
    lp = 1'b1;
    check_true(n > 0, "irq low after enabled pen edge");
    cpu_write(6'h19, 8'h08);
    cpu_write(6'h1a, 8'h00);
    report_test("light pen", first);
  endtask

  task automatic bad_line_refresh();
    int first, line, t, n;
    vic_data_t rd;
    first = err_count;
    read_line(line);
    t = line + 3;
    if (t < `VIC_BADLINE_FIRST || t > `VIC_BADLINE_LAST) begin
      t = `VIC_BADLINE_FIRST; // next frame
    end
    cpu_write(6'h11, {4'b0001, 1'b0, 3'(t)}); // den set with yscroll from target
    clocks_until(1'b1, 1'b0, frame_clocks, n);
    check_true(n > 0, "ba falls on the bad line");
    // vic half of cycle 12 is a refresh access
    check_true(!aec && vic_write_ab && ls245_addr_dir, "address drive in refresh vic half");
    repeat (8) step_clock();
    check_true(aec && !vic_write_ab && !ls245_addr_dir, "cpu half of cycle 12 left to cpu");
    repeat (3 * 16) step_clock(); // cpu half of cycle 15
    check_true(!aec, "aec low in a stolen cpu half");
    clocks_until(1'b1, 1'b1, line_clocks, n);
    check_true(n + 8 + 3 * 16 == (`VIC_STEAL_LAST - `VIC_BA_FIRST + 1) * 16, "ba low length");
    cpu_read(6'h12, rd);
    check_value(rd, 8'(t), "line after ba returns");
    cpu_write(6'h11, 8'h00);
    clocks_until(1'b1, 1'b0, frame_clocks, n);
    check_true(n < 0, "ba stays high with den clear");
    report_test("bad line and refresh", first);
  endtask

  initial begin
    rst_n = 1'b0;
    ce = 1'b1;
    rw = 1'b1;
    lp = 1'b1; // pen idles high
    adi = '0;
    dbi = '0;
    lfsr_q = 32'hf7a536f8;
    err_count = 0;
    check_count = 0;
    reset_and_phase();
    register_access();
    raster_read();
    raster_interrupt();
    light_pen();
    bad_line_refresh();
    err_count += u_vicii.u_checker.fail_count;
    $display("%0d checks, %0d errors", check_count, err_count);
    if (err_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* testbench/vicii_checker.sv */
module vicii_checker (
  input logic clk_dot4x,
  input logic rst_n,
  input logic clk_phi,
  input logic ras,
  input logic cas,
  input logic irq,
  input logic cpu_reset,
  input logic vic_write_ab,
  input logic vic_write_db
);

  int fail_count; // assertion failures, read by the testbench at the end

  // phi is a square wave of 16 dot clocks once the cpu runs
  phi_period: assert property (@(posedge clk_dot4x) disable iff (!rst_n || cpu_reset)
    clk_phi != $past(clk_phi, 8))
    else begin
      $error("clk_phi did not toggle 8 clocks after its last edge");
      fail_count++;
    end

  // cas strobe nested inside ras
  cas_in_ras: assert property (@(posedge clk_dot4x) disable iff (!rst_n) !cas |-> !ras)
    else begin
      $error("cas low while ras high");
      fail_count++;
    end

  // address and data drive never overlap
  one_driver: assert property (@(posedge clk_dot4x) disable iff (!rst_n)
    !(vic_write_ab && vic_write_db))
    else begin
      $error("vic_write_ab and vic_write_db high together");
      fail_count++;
    end

  irq_in_reset: assert property (@(posedge clk_dot4x) disable iff (!rst_n) cpu_reset |-> irq)
    else begin
      $error("irq low during cpu reset hold");
      fail_count++;
    end

endmodule

/* design/vicii.sv */
module vicii import vic_pkg::*; (
  input  logic      clk_dot4x,
  input  logic      rst_n,
  input  logic      ce,         // chip select, low active
  input  logic      rw,         // high read, low write
  input  logic      lp,         // light pen
  input  reg_addr_t adi,
  input  vic_data_t dbi,
  output logic      clk_phi,
  output logic      cpu_reset,
  output logic      ras,
  output logic      cas,
  output logic      irq,
  output logic      ba,
  output logic      aec,
  output bus_addr_t ado,
  output vic_data_t dbo,
  output logic      vic_write_ab, // vic drives address lines
  output logic      vic_write_db, // vic drives data lines
  output logic      ls245_data_dir,
  output logic      ls245_addr_dir
);

  vic_phase_t phase;
  raster_pos_t pos;
  vic_regs_t regs;
  cpu_wr_t wr;
  irq_bits_t status;

  vic_phase_ctrl u_phase_ctrl (
    .clk_dot4x (clk_dot4x),
    .rst_n     (rst_n),
    .phase     (phase),
    .clk_phi   (clk_phi),
    .ras       (ras),
    .cas       (cas),
    .cpu_reset (cpu_reset)
  );

  vic_raster_counter u_raster_counter (
    .clk_dot4x (clk_dot4x),
    .rst_n     (rst_n),
    .phase     (phase),
    .pos       (pos)
  );

  vic_reg_file u_reg_file (
    .clk_dot4x      (clk_dot4x),
    .rst_n          (rst_n),
    .phase          (phase),
    .pos            (pos),
    .status         (status),
    .ce             (ce),
    .rw             (rw),
    .adi            (adi),
    .dbi            (dbi),
    .regs           (regs),
    .wr             (wr),
    .dbo            (dbo),
    .vic_write_db   (vic_write_db),
    .ls245_data_dir (ls245_data_dir)
  );

  vic_irq_unit u_irq_unit (
    .clk_dot4x (clk_dot4x),
    .rst_n     (rst_n),
    .pos       (pos),
    .regs      (regs),
    .wr        (wr),
    .lp        (lp),
    .status    (status),
    .irq       (irq)
  );

  vic_bus_sequencer u_bus_sequencer (
    .clk_dot4x      (clk_dot4x),
    .rst_n          (rst_n),
    .phase          (phase),
    .pos            (pos),
    .regs           (regs),
    .ba             (ba),
    .aec            (aec),
    .ado            (ado),
    .vic_write_ab   (vic_write_ab),
    .ls245_addr_dir (ls245_addr_dir)
  );

endmodule

/* design/vic_bus_sequencer.sv */
`include "vic_defines.svh"

module vic_bus_sequencer import vic_pkg::*; (
  input  logic        clk_dot4x,
  input  logic        rst_n,
  input  vic_phase_t  phase,
  input  raster_pos_t pos,
  input  vic_regs_t   regs,
  output logic        ba,
  output logic        aec,
  output bus_addr_t   ado,
  output logic        vic_write_ab,
  output logic        ls245_addr_dir
);

  logic in_window;   // line inside the bad-line range
  logic badline;
  logic ba_cycle;
  logic aec_cycle;
  logic refresh_cycle;
  logic [7:0] refresh_q;

  assign in_window = (pos.line >= line_t'(`VIC_BADLINE_FIRST)) &&
                     (pos.line <= line_t'(`VIC_BADLINE_LAST));
  assign badline   = regs.den && in_window && (pos.line[2:0] == regs.yscroll);

  // stealing windows in cycle units
  assign ba_cycle  = (pos.cycle >= cycle_t'(`VIC_BA_FIRST)) &&
                     (pos.cycle <= cycle_t'(`VIC_STEAL_LAST));
  assign aec_cycle = (pos.cycle >= cycle_t'(`VIC_AEC_FIRST)) &&
                     (pos.cycle <= cycle_t'(`VIC_STEAL_LAST));

  assign refresh_cycle =
    (pos.cycle >= cycle_t'(`VIC_REFRESH_FIRST)) &&
    (pos.cycle < cycle_t'(`VIC_REFRESH_FIRST + `VIC_REFRESH_PER_LINE));

  assign ba  = !(badline && ba_cycle);
  // vic owns every low half, plus cpu halves while stealing
  assign aec = phase.phi && !(badline && aec_cycle);

  // refresh counter steps down after each refresh access
  always_ff @(posedge clk_dot4x or negedge rst_n) begin
    if (!rst_n) begin
      refresh_q <= 8'hff;
    end else if (phase.cycle_end && refresh_cycle) begin
      refresh_q <= refresh_q - 8'd1;
    end
  end

  // top bits fixed high, bits 7:6 overlap the counter
  assign ado = {`VIC_REFRESH_HIGH, 6'b0} | {4'b0, refresh_q};

  assign vic_write_ab   = phase.running && !phase.phi && refresh_cycle; // vic half only
  assign ls245_addr_dir = vic_write_ab;

endmodule

/* design/vic_irq_unit.sv */
module vic_irq_unit import vic_pkg::*; (
  input  logic        clk_dot4x,
  input  logic        rst_n,
  input  raster_pos_t pos,
  input  vic_regs_t   regs,
  input  cpu_wr_t     wr,
  input  logic        lp,
  output irq_bits_t   status,
  output logic        irq
);

  logic lp_s1;
  logic lp_s2;
  logic lp_prev;   // last synchronised level
  logic lp_fall;
  logic raster_hit;
  irq_bits_t set_bits;
  irq_bits_t clr_bits;
  irq_bits_t status_q;

  assign lp_fall    = lp_prev && !lp_s2;
  assign raster_hit = pos.line_start && (pos.line == regs.raster_cmp);

  // only bits 0 and 3 exist
  assign set_bits = {lp_fall, 2'b00, raster_hit};
  assign clr_bits = (wr.strobe && (wr.addr == 6'h19)) ? wr.data[3:0] : 4'h0; // write 1 to clear

  always_ff @(posedge clk_dot4x or negedge rst_n) begin
    if (!rst_n) begin
      lp_s1    <= 1'b1; // pen idles high
      lp_s2    <= 1'b1;
      lp_prev  <= 1'b1;
      status_q <= '0;
      irq      <= 1'b1;
    end else begin
      lp_s1   <= lp;
      lp_s2   <= lp_s1;
      lp_prev <= lp_s2;
      // set beats a clear on the same clock
      status_q <= ((status_q & ~clr_bits) | set_bits) & 4'b1001;
      irq      <= ~|(status_q & regs.irq_en); // open drain style, active low
    end
  end

  assign status = status_q;

endmodule

/* design/vic_reg_file.sv */
module vic_reg_file import vic_pkg::*; (
  input  logic        clk_dot4x,
  input  logic        rst_n,
  input  vic_phase_t  phase,
  input  raster_pos_t pos,
  input  irq_bits_t   status,
  input  logic        ce,
  input  logic        rw,
  input  reg_addr_t   adi,
  input  vic_data_t   dbi,
  output vic_regs_t   regs,
  output cpu_wr_t     wr,
  output vic_data_t   dbo,
  output logic        vic_write_db,
  output logic        ls245_data_dir
);

  vic_regs_t regs_q;
  logic wr_hit;      // cpu write taken this clock
  logic wr_strobe_q;
  reg_addr_t wr_addr_q;
  vic_data_t wr_data_q;

  // ce and rw both low, sampled late in the cpu half
  assign wr_hit = phase.cpu_sample && !ce && !rw;

  always_ff @(posedge clk_dot4x or negedge rst_n) begin
    if (!rst_n) begin
      regs_q      <= '0;
      wr_strobe_q <= 1'b0;
    end else begin
      wr_strobe_q <= wr_hit;
      if (wr_hit) begin
        case (adi)
          6'h11: begin
            regs_q.raster_cmp[8] <= dbi[7];
            regs_q.den           <= dbi[4];
            regs_q.yscroll       <= dbi[2:0];
          end
          6'h12: regs_q.raster_cmp[7:0] <= dbi;
          6'h1a: regs_q.irq_en <= dbi[3:0];
          6'h20: regs_q.border <= dbi[3:0];
          default: ; // 0x19 handled by the irq unit
        endcase
      end
    end
  end

  // write event payload, only meaningful with the strobe
  always_ff @(posedge clk_dot4x) begin
    if (wr_hit) begin
      wr_addr_q <= adi;
      wr_data_q <= dbi;
    end
  end

  // read data, upper bits of unused fields read as 1
  always_comb begin
    case (adi)
      6'h11:   dbo = {pos.line[8], 2'b00, regs_q.den, 1'b0, regs_q.yscroll};
      6'h12:   dbo = pos.line[7:0];
      6'h19:   dbo = {|(status & regs_q.irq_en), 3'b111, status}; // bit 7 any pending
      6'h1a:   dbo = {4'hf, regs_q.irq_en};
      6'h20:   dbo = {4'hf, regs_q.border};
      default: dbo = 8'hff;
    endcase
  end

  // drive data only in the cpu half of a read
  assign vic_write_db   = phase.phi && !ce && rw;
  assign ls245_data_dir = vic_write_db;

  assign regs      = regs_q;
  assign wr.addr   = wr_addr_q;
  assign wr.data   = wr_data_q;
  assign wr.strobe = wr_strobe_q;

endmodule

/* design/vic_raster_counter.sv */
`include "vic_defines.svh"

module vic_raster_counter import vic_pkg::*; (
  input  logic        clk_dot4x,
  input  logic        rst_n,
  input  vic_phase_t  phase,
  output raster_pos_t pos
);

  cycle_t cycle_q;
  line_t line_q;
  logic start_q;   // line just changed
  logic last_cycle;
  logic last_line;

  assign last_cycle = (cycle_q == cycle_t'(`VIC_CYCLES_PER_LINE - 1));
  assign last_line  = (line_q == line_t'(`VIC_LINES_PER_FRAME - 1));

  always_ff @(posedge clk_dot4x or negedge rst_n) begin
    if (!rst_n) begin
      cycle_q <= '0;
      line_q  <= '0;
      start_q <= 1'b0;
    end else begin
      start_q <= 1'b0; // pulse by default low
      // frozen while the cpu is held in reset
      if (phase.running && phase.cycle_end) begin
        if (last_cycle) begin
          cycle_q <= '0;
          start_q <= 1'b1;
          if (last_line) begin
            line_q <= '0; // frame wrap
          end else begin
            line_q <= line_q + line_t'(1);
          end
        end else begin
          cycle_q <= cycle_q + cycle_t'(1);
        end
      end
    end
  end

  assign pos.cycle      = cycle_q;
  assign pos.line       = line_q;
  assign pos.line_start = start_q;

endmodule

/* design/vic_phase_ctrl.sv */
`include "vic_defines.svh"

module vic_phase_ctrl import vic_pkg::*; (
  input  logic       clk_dot4x,
  input  logic       rst_n,
  output vic_phase_t phase,
  output logic       clk_phi,
  output logic       ras,
  output logic       cas,
  output logic       cpu_reset
);

  localparam int hold_w = $clog2(`VIC_RESET_HOLD_CYCLES + 1);

  phase_state_t state_q;
  phase_state_t state_d;
  subphase_t sub_q;
  subphase_t sub_d;
  logic [hold_w-1:0] hold_q; // phi cycles spent in hold
  logic hold_done;
  logic running;

  assign sub_d = sub_q + subphase_t'(1); // 15 wraps to 0
  assign hold_done = (hold_q == hold_w'(`VIC_RESET_HOLD_CYCLES - 1)) && (sub_q == 4'd15);

  // half-cycle sequencing, hold leaves at a cycle boundary
  always_comb begin
    state_d = state_q;
    case (state_q)
      PH_RESET_HOLD: if (hold_done) state_d = PH_VIC_HALF;
      PH_VIC_HALF:   if (sub_q == 4'd7) state_d = PH_CPU_HALF;
      PH_CPU_HALF:   if (sub_q == 4'd15) state_d = PH_VIC_HALF;
      default:       state_d = PH_RESET_HOLD;
    endcase
  end

  always_ff @(posedge clk_dot4x or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= PH_RESET_HOLD;
      sub_q     <= '0;
      hold_q    <= '0;
      clk_phi   <= 1'b0; // sub-phase 0 is vic half
      ras       <= 1'b1;
      cas       <= 1'b1;
      cpu_reset <= 1'b1;
    end else begin
      state_q <= state_d;
      sub_q   <= sub_d;
      if ((state_q == PH_RESET_HOLD) && (sub_q == 4'd15)) begin
        hold_q <= hold_q + hold_w'(1); // one more phi cycle held
      end
      // strobes decoded from the sub-phase being entered
      clk_phi   <= sub_d[3];            // high for 8..15
      ras       <= (sub_d[2:0] < 3'd2); // low 2-7 and 10-15
      cas       <= ~sub_d[2];           // low 4-7 and 12-15
      cpu_reset <= (state_d == PH_RESET_HOLD); // drops with running
    end
  end

  assign running = (state_q != PH_RESET_HOLD);

  assign phase.subphase   = sub_q;
  assign phase.phi        = clk_phi;
  assign phase.cycle_end  = running && (sub_q == 4'd15);
  assign phase.cpu_sample = (state_q == PH_CPU_HALF) && (sub_q == 4'd14); // bus settled by now
  assign phase.running    = running;

endmodule

/* design/vic_pkg.sv */
package vic_pkg;

  // widths with a meaning on the bus or in the raster
  typedef logic [3:0] subphase_t;  // dot4x step inside one phi cycle
  typedef logic [5:0] cycle_t;     // up to 64 cycles per line
  typedef logic [8:0] line_t;      // up to 512 lines
  typedef logic [5:0] reg_addr_t;  // register window, adi
  typedef logic [7:0] vic_data_t;  // cpu data bus
  typedef logic [11:0] bus_addr_t; // ado
  typedef logic [3:0] irq_bits_t;  // bit 0 raster, bit 3 light pen

  typedef enum logic [1:0] {
    PH_RESET_HOLD, // cpu still in reset
    PH_VIC_HALF,   // phi low
    PH_CPU_HALF    // phi high
  } phase_state_t;

  // timing from the phase generator
  typedef struct packed {
    subphase_t subphase;
    logic phi;
    logic cycle_end;   // last sub-phase of a cycle
    logic cpu_sample;  // sub-phase 14 of a cpu half
    logic running;     // low during reset hold
  } vic_phase_t;

  // raster position
  typedef struct packed {
    cycle_t cycle;
    line_t line;
    logic line_start; // one clock after the line changed
  } raster_pos_t;

  // cpu programmed state
  typedef struct packed {
    line_t raster_cmp;
    logic [2:0] yscroll;
    logic den;
    irq_bits_t irq_en;
    logic [3:0] border;
  } vic_regs_t;

  // one cpu write event
  typedef struct packed {
    reg_addr_t addr;
    vic_data_t data;
    logic strobe;
  } cpu_wr_t;

endpackage

/* design/vic_defines.svh */
`ifndef VIC_DEFINES_SVH
`define VIC_DEFINES_SVH

// raster geometry, one fixed video standard
`define VIC_CYCLES_PER_LINE 63   // phi cycles in one raster line
`define VIC_LINES_PER_FRAME 312  // raster lines in one frame

// lines where a bad line may happen
`define VIC_BADLINE_FIRST 48
`define VIC_BADLINE_LAST 247

// cpu held in reset for this many phi cycles
`define VIC_RESET_HOLD_CYCLES 4

// dram refresh, one access per cycle starting at the first cycle
`define VIC_REFRESH_FIRST 11
`define VIC_REFRESH_PER_LINE 5

// bus stealing window on a bad line
`define VIC_BA_FIRST 12   // ba drops here, three cycles of warning
`define VIC_AEC_FIRST 15  // cpu half taken from here on
`define VIC_STEAL_LAST 54 // last cycle with ba and aec held low

// upper address bits driven during refresh
`define VIC_REFRESH_HIGH 6'h3f

`endif
